//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_ahb_fir_slave
FILELIST  ?= list.f
PASS_MSG  := *** PASSED ***

.PHONY: simulate clean

# Status of the pipe is the status of grep
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- list.f
source/ahb_fir_pkg.sv
source/ahb_phase_fsm.sv
source/sample_regs.sv
source/coeff_regs.sv
source/read_mux.sv
source/ahb_fir_slave.sv
test/tb_clock_gen.sv
test/tb_ahb_fir_slave.sv

//--- source/ahb_fir_pkg.sv
package ahb_fir_pkg;

  // ******************************
  // Widths of the register front end
  // ******************************

  // One bus halfword or register
  typedef logic [15:0] data_t;

  // Byte address into the 16 byte register map
  typedef logic [3:0] addr_t;

  // Index of one of the four FIR coefficients
  typedef logic [1:0] coeff_idx_t;

  // Lane enables, bit 0 is [7:0] and bit 1 is [15:8]
  typedef logic [1:0] byte_en_t;

  // ******************************
  // Address map
  // ******************************

  localparam addr_t ADDR_STATUS     = 4'd0;
  localparam addr_t ADDR_ERROR      = 4'd1;
  localparam addr_t ADDR_RESULT     = 4'd2;
  localparam addr_t ADDR_SAMPLE     = 4'd4;
  localparam addr_t ADDR_COEF_START = 4'd6;
  localparam addr_t ADDR_COEF_SET   = 4'd14;
  localparam addr_t ADDR_INVALID    = 4'd15;

  // F0 to F3, one halfword each
  localparam int NUM_COEFFS = 4;

  // AHB transfer type codes
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // Only the low bit of hsize reaches the slave
  localparam logic HSIZE_BYTE = 1'b0;
  localparam logic HSIZE_HALF = 1'b1;

  // Kind of transfer sitting in its data phase
  typedef enum logic [1:0] {
    PHASE_IDLE,
    PHASE_READ,
    PHASE_WRITE,
    PHASE_ERROR
  } phase_state_t;

endpackage

//--- source/ahb_fir_slave.sv
`timescale 1ns/100ps

module ahb_fir_slave (
  input  logic                    tb_clk,
  input  logic                    reset,
  // AHB-Lite bus side
  input  logic                    hsel,
  input  logic [1:0]              htrans,
  input  ahb_fir_pkg::addr_t      haddr,
  input  logic                    hsize,
  input  logic                    hwrite,
  input  ahb_fir_pkg::data_t      hwdata,
  output ahb_fir_pkg::data_t      hrdata,
  output logic                    hresp,
  // FIR filter side
  input  ahb_fir_pkg::data_t      fir_out,
  input  logic                    modwait,
  input  logic                    err,
  input  ahb_fir_pkg::coeff_idx_t coefficient_num,
  output ahb_fir_pkg::data_t      sample_data,
  output logic                    data_ready,
  output ahb_fir_pkg::data_t      fir_coefficient,
  output logic                    new_coefficient_set
);

  // Data phase controls from the FSM
  ahb_fir_pkg::addr_t    phase_addr;
  ahb_fir_pkg::byte_en_t byte_en;
  logic                  read_active;
  logic                  sample_write;
  logic                  coeff_write;
  logic                  coeff_set_write;

  // Coefficient contents for readback
  ahb_fir_pkg::data_t    coeff_array [ahb_fir_pkg::NUM_COEFFS];

  // ******************************
  // Bus phase tracking
  // ******************************

  ahb_phase_fsm u_phase_fsm (
    .tb_clk(tb_clk), .reset(reset),
    .hsel(hsel), .htrans(htrans), .haddr(haddr), .hsize(hsize), .hwrite(hwrite),
    .phase_addr(phase_addr), .byte_en(byte_en), .read_active(read_active),
    .sample_write(sample_write), .coeff_write(coeff_write),
    .coeff_set_write(coeff_set_write), .hresp(hresp)
  );

  // ******************************
  // Register blocks
  // ******************************

  sample_regs u_sample_regs (
    .tb_clk(tb_clk), .reset(reset), .sample_write(sample_write), .byte_en(byte_en),
    .hwdata(hwdata), .modwait(modwait), .sample_data(sample_data), .data_ready(data_ready)
  );

  coeff_regs u_coeff_regs (
    .tb_clk(tb_clk), .reset(reset), .coeff_write(coeff_write),
    .coeff_set_write(coeff_set_write), .phase_addr(phase_addr), .byte_en(byte_en),
    .hwdata(hwdata), .coefficient_num(coefficient_num), .modwait(modwait),
    .coeff_array(coeff_array), .fir_coefficient(fir_coefficient),
    .new_coefficient_set(new_coefficient_set)
  );

  // Readback path
  read_mux u_read_mux (
    .phase_addr(phase_addr), .read_active(read_active), .modwait(modwait), .err(err),
    .fir_out(fir_out), .sample_data(sample_data), .coeff_array(coeff_array),
    .new_coefficient_set(new_coefficient_set), .hrdata(hrdata)
  );

endmodule

//--- source/ahb_phase_fsm.sv
`timescale 1ns/100ps

module ahb_phase_fsm (
  input  logic                   tb_clk,
  input  logic                   reset,
  input  logic                   hsel,
  input  logic [1:0]             htrans,
  input  ahb_fir_pkg::addr_t     haddr,
  input  logic                   hsize,
  input  logic                   hwrite,
  output ahb_fir_pkg::addr_t     phase_addr,
  output ahb_fir_pkg::byte_en_t  byte_en,
  output logic                   read_active,
  output logic                   sample_write,
  output logic                   coeff_write,
  output logic                   coeff_set_write,
  output logic                   hresp
);

  // Data phase state and next address phase decode
  ahb_fir_pkg::phase_state_t state;
  ahb_fir_pkg::phase_state_t next_state;

  logic                  transfer_valid;
  logic                  read_only_hit;
  logic                  illegal;
  ahb_fir_pkg::addr_t    half_addr;
  ahb_fir_pkg::byte_en_t next_byte_en;

  // ******************************
  // Address phase decode
  // ******************************

  // BUSY and IDLE both count as no transfer
  always_comb begin
    case (htrans)
      ahb_fir_pkg::HTRANS_NONSEQ,
      ahb_fir_pkg::HTRANS_SEQ:  transfer_valid = hsel;
      ahb_fir_pkg::HTRANS_IDLE,
      ahb_fir_pkg::HTRANS_BUSY: transfer_valid = 1'b0;
      default:                  transfer_valid = 1'b0;
    endcase
  end

  // Halfword aligned address, bit 0 dropped
  assign half_addr = {haddr[3:1], 1'b0};

  // Status and result are read only
  assign read_only_hit = (haddr == ahb_fir_pkg::ADDR_STATUS) ||
                         (haddr == ahb_fir_pkg::ADDR_ERROR)  ||
                         (half_addr == ahb_fir_pkg::ADDR_RESULT);

  // Address 15 is never valid
  assign illegal = (haddr == ahb_fir_pkg::ADDR_INVALID) || (hwrite && read_only_hit);

  // Byte picks its lane from address bit 0, halfword takes both
  always_comb begin
    case (hsize)
      ahb_fir_pkg::HSIZE_BYTE: next_byte_en = haddr[0] ? 2'b10 : 2'b01;
      ahb_fir_pkg::HSIZE_HALF: next_byte_en = 2'b11;
      default:                 next_byte_en = 2'b11;
    endcase
  end

  // Next data phase kind
  always_comb begin
    next_state = ahb_fir_pkg::PHASE_IDLE;
    if (transfer_valid) begin
      if (illegal) begin
        next_state = ahb_fir_pkg::PHASE_ERROR;
      end else if (hwrite) begin
        next_state = ahb_fir_pkg::PHASE_WRITE;
      end else begin
        next_state = ahb_fir_pkg::PHASE_READ;
      end
    end
  end

  // ******************************
  // Data phase registers
  // ******************************

  always_ff @(posedge tb_clk) begin
    if (reset) begin
      state           <= ahb_fir_pkg::PHASE_IDLE;
      phase_addr      <= '0;
      byte_en         <= '0;
      sample_write    <= 1'b0;
      coeff_write     <= 1'b0;
      coeff_set_write <= 1'b0;
    end else begin
      state      <= next_state;
      phase_addr <= haddr;
      byte_en    <= next_byte_en;
      // Region strobes only for legal writes
      sample_write <= (next_state == ahb_fir_pkg::PHASE_WRITE) &&
                      (half_addr == ahb_fir_pkg::ADDR_SAMPLE);
      coeff_write  <= (next_state == ahb_fir_pkg::PHASE_WRITE) &&
                      (haddr >= ahb_fir_pkg::ADDR_COEF_START) &&
                      (haddr < ahb_fir_pkg::ADDR_COEF_SET);
      coeff_set_write <= (next_state == ahb_fir_pkg::PHASE_WRITE) &&
                         (haddr == ahb_fir_pkg::ADDR_COEF_SET);
    end
  end

  // Error response spans the whole data phase
  assign hresp       = (state == ahb_fir_pkg::PHASE_ERROR);
  assign read_active = (state == ahb_fir_pkg::PHASE_READ);

endmodule

//--- source/coeff_regs.sv
`timescale 1ns/100ps

module coeff_regs (
  input  logic                    tb_clk,
  input  logic                    reset,
  input  logic                    coeff_write,
  input  logic                    coeff_set_write,
  input  ahb_fir_pkg::addr_t      phase_addr,
  input  ahb_fir_pkg::byte_en_t   byte_en,
  input  ahb_fir_pkg::data_t      hwdata,
  input  ahb_fir_pkg::coeff_idx_t coefficient_num,
  input  logic                    modwait,
  output ahb_fir_pkg::data_t      coeff_array [ahb_fir_pkg::NUM_COEFFS],
  output ahb_fir_pkg::data_t      fir_coefficient,
  output logic                    new_coefficient_set
);

  // Offset into the coefficient block
  ahb_fir_pkg::addr_t      coef_offset;
  ahb_fir_pkg::coeff_idx_t wr_idx;
  logic                    last_coeff_done;

  // ******************************
  // Coefficient write side
  // ******************************

  // Two bytes per coefficient, so bits [2:1] give the index
  assign coef_offset = phase_addr - ahb_fir_pkg::ADDR_COEF_START;
  assign wr_idx      = coef_offset[2:1];

  always_ff @(posedge tb_clk) begin
    if (reset) begin
      for (int i = 0; i < ahb_fir_pkg::NUM_COEFFS; i++) begin
        coeff_array[i] <= '0;
      end
    end else if (coeff_write) begin
      // Low lane
      if (byte_en[0]) begin
        coeff_array[wr_idx][7:0] <= hwdata[7:0];
      end
      // High lane
      if (byte_en[1]) begin
        coeff_array[wr_idx][15:8] <= hwdata[15:8];
      end
    end
  end

  // ******************************
  // Filter side
  // ******************************

  // Filter walks F0..F3 through coefficient_num
  assign fir_coefficient = coeff_array[coefficient_num];

  // Filter has taken F3 while busy
  assign last_coeff_done = modwait &&
                           (coefficient_num == ahb_fir_pkg::coeff_idx_t'(ahb_fir_pkg::NUM_COEFFS - 1));

  // Confirmation flag
  // Host write wins over the filter clear
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      new_coefficient_set <= 1'b0;
    end else if (coeff_set_write && byte_en[0]) begin
      new_coefficient_set <= hwdata[0];
    end else if (last_coeff_done) begin
      new_coefficient_set <= 1'b0;
    end
  end

endmodule

//--- source/read_mux.sv
`timescale 1ns/100ps

module read_mux (
  input  ahb_fir_pkg::addr_t phase_addr,
  input  logic               read_active,
  input  logic               modwait,
  input  logic               err,
  input  ahb_fir_pkg::data_t fir_out,
  input  ahb_fir_pkg::data_t sample_data,
  input  ahb_fir_pkg::data_t coeff_array [ahb_fir_pkg::NUM_COEFFS],
  input  logic               new_coefficient_set,
  output ahb_fir_pkg::data_t hrdata
);

  // Halfword aligned data phase address
  ahb_fir_pkg::addr_t      half_addr;
  ahb_fir_pkg::addr_t      coef_offset;
  ahb_fir_pkg::coeff_idx_t rd_idx;

  assign half_addr = {phase_addr[3:1], 1'b0};

  // Same index math as the write side
  assign coef_offset = half_addr - ahb_fir_pkg::ADDR_COEF_START;
  assign rd_idx      = coef_offset[2:1];

  // ******************************
  // Read data select
  // ******************************

  // Whole halfword goes out, byte reads pick their own lane
  always_comb begin
    hrdata = '0;
    if (read_active) begin
      case (half_addr)
        // Busy in bit 0, error in bit 8
        ahb_fir_pkg::ADDR_STATUS: begin
          hrdata = {7'b0, err, 7'b0, modwait};
        end
        ahb_fir_pkg::ADDR_RESULT: begin
          hrdata = fir_out;
        end
        ahb_fir_pkg::ADDR_SAMPLE: begin
          hrdata = sample_data;
        end
        // Confirmation flag only in bit 0
        ahb_fir_pkg::ADDR_COEF_SET: begin
          hrdata = {15'b0, new_coefficient_set};
        end
        // Everything left is F0..F3
        default: begin
          hrdata = coeff_array[rd_idx];
        end
      endcase
    end
  end

endmodule

//--- source/sample_regs.sv
`timescale 1ns/100ps

module sample_regs (
  input  logic                  tb_clk,
  input  logic                  reset,
  input  logic                  sample_write,
  input  ahb_fir_pkg::byte_en_t byte_en,
  input  ahb_fir_pkg::data_t    hwdata,
  input  logic                  modwait,
  output ahb_fir_pkg::data_t    sample_data,
  output logic                  data_ready
);

  // ******************************
  // New sample register
  // ******************************

  // Each lane updates on its own enable
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      sample_data <= '0;
    end else if (sample_write) begin
      // Low byte from hwdata[7:0]
      if (byte_en[0]) begin
        sample_data[7:0] <= hwdata[7:0];
      end
      // High byte from hwdata[15:8]
      if (byte_en[1]) begin
        sample_data[15:8] <= hwdata[15:8];
      end
    end
  end

  // ******************************
  // Handshake to the filter
  // ******************************

  // Raised by any sample write
  // Dropped once the filter reports busy
  // A write in the same cycle keeps it up for the fresh sample
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      data_ready <= 1'b0;
    end else if (sample_write) begin
      data_ready <= 1'b1;
    end else if (modwait) begin
      data_ready <= 1'b0;
    end
  end

endmodule

//--- test/tb_ahb_fir_slave.sv
`timescale 1ns/100ps

module tb_ahb_fir_slave;

  // Cycles allowed for a flag to settle
  localparam int FLAG_TIMEOUT = 20;
  localparam int COEFF_COUNT  = 4;

  logic                    tb_clk, reset;
  logic                    hsel, hsize, hwrite, hresp;
  logic [1:0]              htrans;
  ahb_fir_pkg::addr_t      haddr;
  ahb_fir_pkg::data_t      hwdata, hrdata, fir_out, sample_data, fir_coefficient;
  logic                    modwait, err, data_ready, new_coefficient_set;
  ahb_fir_pkg::coeff_idx_t coefficient_num;

  // Expected register contents
  ahb_fir_pkg::data_t sample_model;
  ahb_fir_pkg::data_t coeff_model [COEFF_COUNT];
  ahb_fir_pkg::data_t rd;
  int                 errors, checks;

  tb_clock_gen u_clock_gen (.tb_clk(tb_clk));

  ahb_fir_slave dut (
    .tb_clk(tb_clk), .reset(reset), .hsel(hsel), .htrans(htrans), .haddr(haddr),
    .hsize(hsize), .hwrite(hwrite), .hwdata(hwdata), .hrdata(hrdata), .hresp(hresp),
    .fir_out(fir_out), .modwait(modwait), .err(err), .coefficient_num(coefficient_num),
    .sample_data(sample_data), .data_ready(data_ready), .fir_coefficient(fir_coefficient),
    .new_coefficient_set(new_coefficient_set)
  );

  // ******************************
  // Checking and bus drive
  // ******************************

  task automatic check_value(input string name, input ahb_fir_pkg::data_t expected,
                             input ahb_fir_pkg::data_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // One NONSEQ address phase
  task automatic drive_addr(input ahb_fir_pkg::addr_t addr, input logic size, input logic write);
    hsel   = 1'b1;
    htrans = ahb_fir_pkg::HTRANS_NONSEQ;
    haddr  = addr;
    hsize  = size;
    hwrite = write;
  endtask

  task automatic bus_write(input string name, input ahb_fir_pkg::addr_t addr, input logic size,
                           input ahb_fir_pkg::data_t data, input logic exp_resp);
    @(negedge tb_clk);
    drive_addr(addr, size, 1'b1);
    @(negedge tb_clk);
    hsel   = 1'b0;
    htrans = ahb_fir_pkg::HTRANS_IDLE;
    hwdata = data;
    check_value({name, " hresp"}, ahb_fir_pkg::data_t'(exp_resp), ahb_fir_pkg::data_t'(hresp));
    // Register holds the new value after the closing edge
    @(negedge tb_clk);
  endtask

  // hrdata taken mid data phase
  task automatic bus_read(input string name, input ahb_fir_pkg::addr_t addr, input logic size,
                          input logic exp_resp, output ahb_fir_pkg::data_t data);
    @(negedge tb_clk);
    drive_addr(addr, size, 1'b0);
    @(negedge tb_clk);
    hsel   = 1'b0;
    htrans = ahb_fir_pkg::HTRANS_IDLE;
    data   = hrdata;
    check_value({name, " hresp"}, ahb_fir_pkg::data_t'(exp_resp), ahb_fir_pkg::data_t'(hresp));
  endtask

  // Two halfword writes with the second address phase inside the first data phase
  task automatic bus_pair(input string name, input ahb_fir_pkg::addr_t addr_a,
                          input ahb_fir_pkg::data_t data_a, input ahb_fir_pkg::addr_t addr_b,
                          input ahb_fir_pkg::data_t data_b);
    @(negedge tb_clk);
    drive_addr(addr_a, ahb_fir_pkg::HSIZE_HALF, 1'b1);
    @(negedge tb_clk);
    drive_addr(addr_b, ahb_fir_pkg::HSIZE_HALF, 1'b1);
    hwdata = data_a;
    check_value({name, " hresp a"}, 16'h0000, ahb_fir_pkg::data_t'(hresp));
    @(negedge tb_clk);
    hsel   = 1'b0;
    htrans = ahb_fir_pkg::HTRANS_IDLE;
    hwdata = data_b;
    check_value({name, " hresp b"}, 16'h0000, ahb_fir_pkg::data_t'(hresp));
    @(negedge tb_clk);
  endtask

  // Waits for data_ready or new_coefficient_set to reach a level
  task automatic wait_flag(input bit coeff_flag, input logic level);
    int   cycles;
    logic flag;
    cycles = 0;
    flag   = coeff_flag ? new_coefficient_set : data_ready;
    while (flag !== level && cycles < FLAG_TIMEOUT) begin
      @(negedge tb_clk);
      cycles++;
      flag = coeff_flag ? new_coefficient_set : data_ready;
    end
    if (flag !== level) begin
      errors++;
      $display("Timeout: %s never reached %b", coeff_flag ? "new_coefficient_set" : "data_ready",
               level);
    end
  endtask

  // ******************************
  // Directed tests
  // ******************************

  task automatic test_reset();
    // Filter inputs all active through reset
    modwait         = 1'b1;
    err             = 1'b1;
    coefficient_num = 2'd3;
    fir_out         = ahb_fir_pkg::data_t'($urandom());
    repeat (2) @(negedge tb_clk);
    reset = 1'b0;
    check_value("reset sample_data", 16'h0000, sample_data);
    check_value("reset fir_coefficient", 16'h0000, fir_coefficient);
    check_value("reset data_ready", 16'h0000, ahb_fir_pkg::data_t'(data_ready));
    check_value("reset coef set", 16'h0000, ahb_fir_pkg::data_t'(new_coefficient_set));
    check_value("reset hresp", 16'h0000, ahb_fir_pkg::data_t'(hresp));
    modwait         = 1'b0;
    err             = 1'b0;
    coefficient_num = 2'd0;
  endtask

  task automatic test_sample();
    sample_model = ahb_fir_pkg::data_t'($urandom());
    bus_write("sample write", ahb_fir_pkg::ADDR_SAMPLE, ahb_fir_pkg::HSIZE_HALF,
              sample_model, 1'b0);
    wait_flag(1'b0, 1'b1);
    bus_read("sample read", ahb_fir_pkg::ADDR_SAMPLE, ahb_fir_pkg::HSIZE_HALF, 1'b0, rd);
    check_value("sample read", sample_model, rd);
    check_value("sample_data", sample_model, sample_data);
    check_value("data_ready high", 16'h0001, ahb_fir_pkg::data_t'(data_ready));
    // One busy cycle from the filter drops the flag on its edge
    modwait = 1'b1;
    @(negedge tb_clk);
    check_value("data_ready low", 16'h0000, ahb_fir_pkg::data_t'(data_ready));
    modwait = 1'b0;
  endtask

  task automatic test_byte_lanes();
    ahb_fir_pkg::data_t value;
    // Unused lane of hwdata carries random junk
    value = ahb_fir_pkg::data_t'($urandom());
    bus_write("byte low write", ahb_fir_pkg::ADDR_SAMPLE, ahb_fir_pkg::HSIZE_BYTE, value, 1'b0);
    sample_model[7:0] = value[7:0];
    check_value("byte low", sample_model, sample_data);
    value = ahb_fir_pkg::data_t'($urandom());
    bus_write("byte high write", ahb_fir_pkg::ADDR_SAMPLE + 4'd1, ahb_fir_pkg::HSIZE_BYTE, value,
              1'b0);
    sample_model[15:8] = value[15:8];
    check_value("byte high", sample_model, sample_data);
    bus_read("byte low read", ahb_fir_pkg::ADDR_SAMPLE, ahb_fir_pkg::HSIZE_BYTE, 1'b0, rd);
    check_value("byte low lane", {8'h00, sample_model[7:0]}, {8'h00, rd[7:0]});
    bus_read("byte high read", ahb_fir_pkg::ADDR_SAMPLE + 4'd1, ahb_fir_pkg::HSIZE_BYTE, 1'b0, rd);
    check_value("byte high lane", {sample_model[15:8], 8'h00}, {rd[15:8], 8'h00});
  endtask

  // Walks coefficient_num over F0..F3
  task automatic check_fir_coefficients(input string name);
    for (int i = 0; i < COEFF_COUNT; i++) begin
      coefficient_num = ahb_fir_pkg::coeff_idx_t'(i);
      @(negedge tb_clk);
      check_value(name, coeff_model[i], fir_coefficient);
    end
  endtask

  task automatic test_coeffs();
    for (int i = 0; i < COEFF_COUNT; i++) begin
      coeff_model[i] = ahb_fir_pkg::data_t'($urandom());
    end
    bus_pair("coef pair 0", ahb_fir_pkg::ADDR_COEF_START, coeff_model[0],
             ahb_fir_pkg::ADDR_COEF_START + 4'd2, coeff_model[1]);
    bus_pair("coef pair 1", ahb_fir_pkg::ADDR_COEF_START + 4'd4, coeff_model[2],
             ahb_fir_pkg::ADDR_COEF_START + 4'd6, coeff_model[3]);
    for (int i = 0; i < COEFF_COUNT; i++) begin
      bus_read("coef read", ahb_fir_pkg::addr_t'(ahb_fir_pkg::ADDR_COEF_START + 2 * i),
               ahb_fir_pkg::HSIZE_HALF, 1'b0, rd);
      check_value("coef read", coeff_model[i], rd);
    end
    check_fir_coefficients("fir_coefficient");
  endtask

  task automatic test_status();
    ahb_fir_pkg::data_t expected;
    for (int i = 0; i < 4; i++) begin
      modwait     = i[0];
      err         = i[1];
      // Busy in bit 0 and error in bit 8
      expected    = 16'h0000;
      expected[0] = i[0];
      expected[8] = i[1];
      bus_read("status read", ahb_fir_pkg::ADDR_STATUS, ahb_fir_pkg::HSIZE_HALF, 1'b0, rd);
      check_value("status read", expected, rd);
    end
    modwait = 1'b0;
    err     = 1'b0;
    fir_out = ahb_fir_pkg::data_t'($urandom());
    bus_read("result read", ahb_fir_pkg::ADDR_RESULT, ahb_fir_pkg::HSIZE_HALF, 1'b0, rd);
    check_value("result read", fir_out, rd);
  endtask

  task automatic test_errors();
    coefficient_num = 2'd0;
    bus_write("write status", ahb_fir_pkg::ADDR_STATUS, ahb_fir_pkg::HSIZE_HALF,
              ahb_fir_pkg::data_t'($urandom()), 1'b1);
    bus_write("write result", ahb_fir_pkg::ADDR_RESULT, ahb_fir_pkg::HSIZE_HALF,
              ahb_fir_pkg::data_t'($urandom()), 1'b1);
    bus_write("write invalid", ahb_fir_pkg::ADDR_INVALID, ahb_fir_pkg::HSIZE_BYTE, 16'hffff, 1'b1);
    check_value("hresp after error", 16'h0000, ahb_fir_pkg::data_t'(hresp));
    bus_read("read invalid", ahb_fir_pkg::ADDR_INVALID, ahb_fir_pkg::HSIZE_BYTE, 1'b1, rd);
    check_value("sample kept", sample_model, sample_data);
    check_value("coef set kept", 16'h0000, ahb_fir_pkg::data_t'(new_coefficient_set));
    check_fir_coefficients("coef kept");
    // Host confirms the coefficient set
    coefficient_num = 2'd0;
    bus_write("coef set write", ahb_fir_pkg::ADDR_COEF_SET, ahb_fir_pkg::HSIZE_HALF,
              16'h0001, 1'b0);
    wait_flag(1'b1, 1'b1);
    bus_read("coef set read", ahb_fir_pkg::ADDR_COEF_SET, ahb_fir_pkg::HSIZE_HALF, 1'b0, rd);
    check_value("coef set read", 16'h0001, rd);
    // Filter takes F3 while busy and the flag drops on that edge
    coefficient_num = 2'd3;
    modwait         = 1'b1;
    @(negedge tb_clk);
    check_value("coef set cleared", 16'h0000, ahb_fir_pkg::data_t'(new_coefficient_set));
    modwait = 1'b0;
  endtask

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    errors          = 0;
    checks          = 0;
    void'($urandom(32'h6107df65));
    reset           = 1'b1;
    hsel            = 1'b0;
    htrans          = ahb_fir_pkg::HTRANS_IDLE;
    haddr           = '0;
    hsize           = ahb_fir_pkg::HSIZE_HALF;
    hwrite          = 1'b0;
    hwdata          = '0;
    fir_out         = '0;
    modwait         = 1'b0;
    err             = 1'b0;
    coefficient_num = '0;
    test_reset();
    test_sample();
    test_byte_lanes();
    test_coeffs();
    test_status();
    test_errors();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
  output logic tb_clk
);

  // 10 ns period, first rising edge at 5 ns
  initial begin
    tb_clk = 1'b0;
    forever #5 tb_clk = ~tb_clk;
  end

endmodule
